// File: verilog/isa_pkg.sv
package isa_pkg;

    localparam int XLEN = 32;
    localparam int REG_ID_W = 5;

    // instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // funct7 value that selects sub
    localparam logic [FUNCT7_W - 1:0] FUNCT7_ALT = 7'b0100000;

    // branch funct3 values
    localparam logic [FUNCT3_W - 1:0] F3_BEQ = 3'b000;
    localparam logic [FUNCT3_W - 1:0] F3_BNE = 3'b001;

    typedef enum logic [OPCODE_W - 1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011
    } opcode_e;

    // funct3 for OP and OP_IMM
    typedef enum logic [FUNCT3_W - 1:0] {
        F3_ADD = 3'b000,
        F3_SLL = 3'b001,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_SRL = 3'b101,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        NONE,
        EQ,
        NE
    } branch_e;

endpackage

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    // wishbone classic, read side only
    typedef struct packed {
        logic cyc;
        logic stb;
        logic [isa_pkg::XLEN - 1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic [isa_pkg::XLEN - 1:0] dat_r;
    } wb_rsp_t;

    // fetch -> decode
    typedef struct packed {
        logic [isa_pkg::XLEN - 1:0] pc;
        logic [isa_pkg::XLEN - 1:0] instr;
    } fetch_pack_t;

    // decode -> execute
    typedef struct packed {
        logic [isa_pkg::XLEN - 1:0] pc;
        isa_pkg::alu_op_e alu_op;
        isa_pkg::branch_e branch;
        logic [isa_pkg::XLEN - 1:0] op_a;
        logic [isa_pkg::XLEN - 1:0] op_b;
        logic [isa_pkg::XLEN - 1:0] br_off;
        logic [isa_pkg::REG_ID_W - 1:0] rd;
        logic we;
    } decode_pack_t;

    // execute -> result
    typedef struct packed {
        logic [isa_pkg::XLEN - 1:0] pc;
        logic [isa_pkg::REG_ID_W - 1:0] rd;
        logic we;
        logic is_branch;
        logic [isa_pkg::XLEN - 1:0] value;
        logic [isa_pkg::XLEN - 1:0] next_pc;
    } exec_pack_t;

    typedef struct packed {
        logic [isa_pkg::XLEN - 1:0] pc;
        logic [isa_pkg::REG_ID_W - 1:0] rd;
        logic [isa_pkg::XLEN - 1:0] data;
    } retire_t;

endpackage

// File: verilog/fetch_unit.sv
module fetch_unit #(
    parameter logic [isa_pkg::XLEN - 1:0] RESET_PC = '0
)(
    input  logic clk,
    input  logic arst_n,
    input  pipe_pkg::wb_rsp_t wb_rsp,
    input  logic redirect_valid,
    input  logic [isa_pkg::XLEN - 1:0] redirect_pc,
    output pipe_pkg::wb_req_t wb_req,
    output logic fetch_valid,
    output pipe_pkg::fetch_pack_t fetch
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_RETIRE
    } state_e;

    state_e state;
    logic [isa_pkg::XLEN - 1:0] pc;
    logic req_active;
    logic ack_taken;

    assign req_active = (state == REQ);
    assign ack_taken = req_active && wb_rsp.ack;

    // cyc and stb rise and fall together
    always_comb begin
        wb_req.cyc = req_active;
        wb_req.stb = req_active;
        wb_req.adr = pc;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            pc <= RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                IDLE: begin
                    state <= REQ;
                end
                REQ: begin
                    if (wb_rsp.ack) begin
                        fetch_valid <= 1'b1;
                        state <= WAIT_RETIRE;
                    end
                end
                WAIT_RETIRE: begin
                    // next pc comes back from the retire stage
                    if (redirect_valid) begin
                        pc <= redirect_pc;
                        state <= REQ;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ack_taken) begin
            fetch.pc <= pc;
            fetch.instr <= wb_rsp.dat_r;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) wb_req.stb |-> wb_req.cyc);

    // address held until the slave answers
    assert property (@(posedge clk) disable iff (!arst_n)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr));

endmodule

// File: verilog/decode.sv
module decode (
    input  logic clk,
    input  logic arst_n,
    input  logic fetch_valid,
    input  pipe_pkg::fetch_pack_t fetch,
    input  logic [isa_pkg::XLEN - 1:0] rs1_data,
    input  logic [isa_pkg::XLEN - 1:0] rs2_data,
    output logic [isa_pkg::REG_ID_W - 1:0] rs1_id,
    output logic [isa_pkg::REG_ID_W - 1:0] rs2_id,
    output logic dec_valid,
    output pipe_pkg::decode_pack_t dec
);

    isa_pkg::opcode_e opcode;
    isa_pkg::funct3_e funct3;
    logic [isa_pkg::FUNCT7_W - 1:0] funct7;
    logic [isa_pkg::REG_ID_W - 1:0] rd;
    logic [isa_pkg::XLEN - 1:0] imm_i;
    logic [isa_pkg::XLEN - 1:0] imm_u;
    logic [isa_pkg::XLEN - 1:0] imm_b;
    logic alt_op;
    pipe_pkg::decode_pack_t nxt;

    // PASS_B marks an unsupported funct3
    function automatic isa_pkg::alu_op_e alu_sel(
        input isa_pkg::funct3_e f3,
        input logic alt
    );
        isa_pkg::alu_op_e op;
        case (f3)
            isa_pkg::F3_ADD: op = alt ? isa_pkg::SUB : isa_pkg::ADD;
            isa_pkg::F3_SLL: op = isa_pkg::SLL;
            isa_pkg::F3_SLT: op = isa_pkg::SLT;
            isa_pkg::F3_XOR: op = isa_pkg::XOR;
            isa_pkg::F3_SRL: op = isa_pkg::SRL;
            isa_pkg::F3_OR:  op = isa_pkg::OR;
            isa_pkg::F3_AND: op = isa_pkg::AND;
            default:         op = isa_pkg::PASS_B;
        endcase
        return op;
    endfunction

    assign opcode = isa_pkg::opcode_e'(fetch.instr[isa_pkg::OPCODE_W - 1:0]);
    assign funct3 = isa_pkg::funct3_e'(fetch.instr[14:12]);
    assign funct7 = fetch.instr[31:25];
    assign rd = fetch.instr[11:7];
    assign rs1_id = fetch.instr[19:15];
    assign rs2_id = fetch.instr[24:20];
    assign alt_op = (funct7 == isa_pkg::FUNCT7_ALT);

    assign imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
    assign imm_u = {fetch.instr[31:12], 12'b0};
    assign imm_b = {{19{fetch.instr[31]}}, fetch.instr[31], fetch.instr[7],
                    fetch.instr[30:25], fetch.instr[11:8], 1'b0};

    always_comb begin
        nxt.pc = fetch.pc;
        nxt.op_a = rs1_data;
        nxt.op_b = rs2_data;
        nxt.br_off = imm_b;
        nxt.rd = rd;
        nxt.alu_op = isa_pkg::PASS_B;
        nxt.branch = isa_pkg::NONE;
        nxt.we = 1'b0;
        case (opcode)
            isa_pkg::OP: begin
                // funct7 alt only legal for sub
                if (funct7 == '0 || (alt_op && funct3 == isa_pkg::F3_ADD)) begin
                    nxt.alu_op = alu_sel(funct3, alt_op);
                    nxt.we = (nxt.alu_op != isa_pkg::PASS_B);
                end
            end
            isa_pkg::OP_IMM: begin
                // no immediate shifts in this subset
                if (funct3 != isa_pkg::F3_SLL && funct3 != isa_pkg::F3_SRL) begin
                    nxt.alu_op = alu_sel(funct3, 1'b0);
                    nxt.op_b = imm_i;
                    nxt.we = (nxt.alu_op != isa_pkg::PASS_B);
                end
            end
            isa_pkg::LUI: begin
                nxt.op_b = imm_u;
                nxt.we = 1'b1;
            end
            isa_pkg::BRANCH: begin
                if (funct3 == isa_pkg::F3_BEQ) begin
                    nxt.branch = isa_pkg::EQ;
                end else if (funct3 == isa_pkg::F3_BNE) begin
                    nxt.branch = isa_pkg::NE;
                end
            end
            default: begin
                nxt.we = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            dec <= nxt;
        end
    end

endmodule

// File: verilog/execute.sv
module execute (
    input  logic clk,
    input  logic arst_n,
    input  logic dec_valid,
    input  pipe_pkg::decode_pack_t dec,
    output logic ex_valid,
    output pipe_pkg::exec_pack_t ex
);

    localparam int SHAMT_W = $clog2(isa_pkg::XLEN);

    logic [isa_pkg::XLEN - 1:0] alu_out;
    logic [isa_pkg::XLEN - 1:0] next_pc;
    logic [SHAMT_W - 1:0] shamt;
    logic less;
    logic taken;

    // shifts use only the low bits of operand b
    assign shamt = dec.op_b[SHAMT_W - 1:0];
    assign less = $signed(dec.op_a) < $signed(dec.op_b);

    always_comb begin
        case (dec.alu_op)
            isa_pkg::ADD:    alu_out = dec.op_a + dec.op_b;
            isa_pkg::SUB:    alu_out = dec.op_a - dec.op_b;
            isa_pkg::AND:    alu_out = dec.op_a & dec.op_b;
            isa_pkg::OR:     alu_out = dec.op_a | dec.op_b;
            isa_pkg::XOR:    alu_out = dec.op_a ^ dec.op_b;
            isa_pkg::SLT:    alu_out = {{(isa_pkg::XLEN - 1){1'b0}}, less};
            isa_pkg::SLL:    alu_out = dec.op_a << shamt;
            isa_pkg::SRL:    alu_out = dec.op_a >> shamt;
            isa_pkg::PASS_B: alu_out = dec.op_b;
            default:         alu_out = dec.op_b;
        endcase
    end

    always_comb begin
        case (dec.branch)
            isa_pkg::EQ: taken = (dec.op_a == dec.op_b);
            isa_pkg::NE: taken = (dec.op_a != dec.op_b);
            default:     taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? dec.pc + dec.br_off : dec.pc + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex.pc <= dec.pc;
            ex.rd <= dec.rd;
            ex.we <= dec.we;
            ex.is_branch <= (dec.branch != isa_pkg::NONE);
            ex.value <= alu_out;
            ex.next_pc <= next_pc;
        end
    end

    // decode must never mark a branch as writing
    assert property (@(posedge clk) disable iff (!arst_n) ex_valid && ex.is_branch |-> !ex.we);

endmodule

// File: verilog/result.sv
module result (
    input  logic clk,
    input  logic arst_n,
    input  logic ex_valid,
    input  pipe_pkg::exec_pack_t ex,
    input  logic [isa_pkg::REG_ID_W - 1:0] rs1_id,
    input  logic [isa_pkg::REG_ID_W - 1:0] rs2_id,
    output logic [isa_pkg::XLEN - 1:0] rs1_data,
    output logic [isa_pkg::XLEN - 1:0] rs2_data,
    output logic retire_valid,
    output pipe_pkg::retire_t retire,
    output logic redirect_valid,
    output logic [isa_pkg::XLEN - 1:0] redirect_pc
);

    // x0 has no storage
    logic [isa_pkg::XLEN - 1:0] regs [1:31];
    logic wr;

    assign wr = ex_valid && ex.we && (ex.rd != '0);

    assign rs1_data = (rs1_id == '0) ? '0 : regs[rs1_id];
    assign rs2_data = (rs2_id == '0) ? '0 : regs[rs2_id];

    always_ff @(posedge clk) begin
        if (wr) begin
            regs[ex.rd] <= ex.value;
        end
    end

    always_comb begin
        retire_valid = ex_valid;
        retire.pc = ex.pc;
        retire.rd = wr ? ex.rd : '0;
        if (ex.is_branch) begin
            retire.data = ex.next_pc;
        end else if (wr) begin
            retire.data = ex.value;
        end else begin
            retire.data = '0;
        end
    end

    // fetch waits on this
    assign redirect_valid = ex_valid;
    assign redirect_pc = ex.next_pc;

    // no-ops and x0 writes retire empty
    assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && retire.rd == '0 && !ex.is_branch |-> retire.data == '0);

endmodule

// File: verilog/core_top.sv
module core_top #(
    parameter logic [isa_pkg::XLEN - 1:0] RESET_PC = '0
)(
    input  logic clk,
    input  logic arst_n,
    input  pipe_pkg::wb_rsp_t wb_rsp,
    output pipe_pkg::wb_req_t wb_req,
    output logic retire_valid,
    output pipe_pkg::retire_t retire
);

    //fetch->decode
    logic fetch_valid;
    pipe_pkg::fetch_pack_t fetch;

    //decode<->result register file
    logic [isa_pkg::REG_ID_W - 1:0] rs1_id;
    logic [isa_pkg::REG_ID_W - 1:0] rs2_id;
    logic [isa_pkg::XLEN - 1:0] rs1_data;
    logic [isa_pkg::XLEN - 1:0] rs2_data;

    //decode->execute
    logic dec_valid;
    pipe_pkg::decode_pack_t dec;

    //execute->result
    logic ex_valid;
    pipe_pkg::exec_pack_t ex;

    //result->fetch
    logic redirect_valid;
    logic [isa_pkg::XLEN - 1:0] redirect_pc;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .clk(clk),
        .arst_n(arst_n),
        .wb_rsp(wb_rsp),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc),
        .wb_req(wb_req),
        .fetch_valid(fetch_valid),
        .fetch(fetch)
    );

    decode decode_inst (
        .clk(clk),
        .arst_n(arst_n),
        .fetch_valid(fetch_valid),
        .fetch(fetch),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rs1_id(rs1_id),
        .rs2_id(rs2_id),
        .dec_valid(dec_valid),
        .dec(dec)
    );

    execute execute_inst (
        .clk(clk),
        .arst_n(arst_n),
        .dec_valid(dec_valid),
        .dec(dec),
        .ex_valid(ex_valid),
        .ex(ex)
    );

    result result_inst (
        .clk(clk),
        .arst_n(arst_n),
        .ex_valid(ex_valid),
        .ex(ex),
        .rs1_id(rs1_id),
        .rs2_id(rs2_id),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .retire_valid(retire_valid),
        .retire(retire),
        .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc)
    );

endmodule

// File: verif/test_program.svh
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

// instruction words, one per word address from pc 0
localparam int NUM_WORDS = 30;

localparam logic [31:0] PROGRAM_WORDS [0:NUM_WORDS - 1] = '{
    // x1 = 5, x2 = -3
    32'h00500093,
    32'hFFD00113,
    // add sub slt sll srl xor or and
    32'h002081B3,
    32'h40208233,
    32'h001122B3,
    32'h00209333,
    32'h001353B3,
    32'h0020C433,
    32'h0020E4B3,
    32'h0020F533,
    // lui x11, then ori andi xori slti
    32'h123455B7,
    32'h6785E613,
    32'hF0067693,
    32'hFFF0C713,
    32'hFFE12793,
    // addi x0, x1, 7 then add x16, x0, x1
    32'h00708013,
    32'h00100833,
    // beq taken over two words, bne not taken, bne taken, beq not taken
    32'h00A08663,
    32'h00100893,
    32'h00200893,
    32'h00A09463,
    32'h00209463,
    32'h00300893,
    32'h00208463,
    // addi x17, x16, 9
    32'h00980893,
    // two-pass loop on x18 with a backward bne
    32'h00200913,
    32'hFFF90913,
    32'hFE091EE3,
    // sub x19, x0, x16
    32'h410009B3,
    32'h00000013
};

// pc, rd, data of each retire, in retire order
localparam int NUM_RETIRES = 28;

localparam pipe_pkg::retire_t EXPECTED_RETIRES [0:NUM_RETIRES - 1] = '{
    {32'h00000000, 5'd1, 32'h00000005},
    {32'h00000004, 5'd2, 32'hFFFFFFFD},
    {32'h00000008, 5'd3, 32'h00000002},
    {32'h0000000C, 5'd4, 32'h00000008},
    {32'h00000010, 5'd5, 32'h00000001},
    {32'h00000014, 5'd6, 32'hA0000000},
    {32'h00000018, 5'd7, 32'h05000000},
    {32'h0000001C, 5'd8, 32'hFFFFFFF8},
    {32'h00000020, 5'd9, 32'hFFFFFFFD},
    {32'h00000024, 5'd10, 32'h00000005},
    {32'h00000028, 5'd11, 32'h12345000},
    {32'h0000002C, 5'd12, 32'h12345678},
    {32'h00000030, 5'd13, 32'h12345600},
    {32'h00000034, 5'd14, 32'hFFFFFFFA},
    {32'h00000038, 5'd15, 32'h00000001},
    {32'h0000003C, 5'd0, 32'h00000000},
    {32'h00000040, 5'd16, 32'h00000005},
    {32'h00000044, 5'd0, 32'h00000050},
    {32'h00000050, 5'd0, 32'h00000054},
    {32'h00000054, 5'd0, 32'h0000005C},
    {32'h0000005C, 5'd0, 32'h00000060},
    {32'h00000060, 5'd17, 32'h0000000E},
    {32'h00000064, 5'd18, 32'h00000002},
    {32'h00000068, 5'd18, 32'h00000001},
    {32'h0000006C, 5'd0, 32'h00000068},
    {32'h00000068, 5'd18, 32'h00000000},
    {32'h0000006C, 5'd0, 32'h00000070},
    {32'h00000070, 5'd19, 32'hFFFFFFFB}
};

`endif

// File: verif/core_top_tb.sv
module core_top_tb;

    localparam logic [isa_pkg::XLEN - 1:0] RESET_PC = '0;
    localparam int RESET_CYCLES = 3;
    // edges from the one that samples ack to the one that samples retire
    localparam int RETIRE_LATENCY = 3;
    localparam logic [31:0] NOP_WORD = 32'h00000013;

    `include "test_program.svh"

    localparam int CYCLE_LIMIT = NUM_RETIRES * 10 + 20;

    logic clk = 1'b0;
    logic arst_n;
    pipe_pkg::wb_rsp_t wb_rsp = '0;
    pipe_pkg::wb_req_t wb_req;
    logic retire_valid;
    pipe_pkg::retire_t retire;

    integer seed = 32'hac3c2dc1;
    int cycles = 0;
    int ack_cycle = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int current_test = 0;
    int wait_left = 0;
    logic in_request = 1'b0;

    core_top #(
        .RESET_PC(RESET_PC)
    ) core_top_inst (
        .clk(clk),
        .arst_n(arst_n),
        .wb_rsp(wb_rsp),
        .wb_req(wb_req),
        .retire_valid(retire_valid),
        .retire(retire)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: retire %0d not seen within %0d cycles", current_test, CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] read_word(input logic [31:0] adr);
        logic [31:0] word;
        if (adr < 32'(NUM_WORDS * 4)) begin
            word = PROGRAM_WORDS[adr[6:2]];
        end else begin
            word = NOP_WORD;
        end
        return word;
    endfunction

    task automatic compare_value(
        input string name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail", name);
        end
    endtask

    // wishbone slave, 0 to 3 wait states before each ack
    always @(negedge clk) begin
        if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
        end else if (arst_n && wb_req.cyc && wb_req.stb) begin
            if (!in_request) begin
                in_request = 1'b1;
                wait_left = int'($unsigned($random(seed)) % 4);
            end
            if (wait_left == 0) begin
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat_r <= read_word(wb_req.adr);
                ack_cycle <= cycles;
                in_request = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    initial begin
        int errors_before;
        arst_n = 1'b0;
        errors_before = errors;
        // bus and retire port quiet while reset is held
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
            compare_value("wb_req.stb", 32'(wb_req.stb), 32'd0);
            compare_value("retire_valid", 32'(retire_valid), 32'd0);
        end
        arst_n <= 1'b1;
        @(negedge clk);
        while (!wb_req.cyc) begin
            @(negedge clk);
        end
        compare_value("wb_req.adr", wb_req.adr, RESET_PC);
        report_test("reset", errors_before);

        for (int i = 0; i < NUM_RETIRES; i++) begin
            current_test = i;
            errors_before = errors;
            @(negedge clk);
            while (!retire_valid) begin
                @(negedge clk);
            end
            compare_value("retire.pc", retire.pc, EXPECTED_RETIRES[i].pc);
            compare_value("retire.rd", 32'(retire.rd), 32'(EXPECTED_RETIRES[i].rd));
            compare_value("retire.data", retire.data, EXPECTED_RETIRES[i].data);
            // both counts taken on falling edges, one before each sampling edge
            compare_value("ack_to_retire", 32'(cycles - ack_cycle), 32'(RETIRE_LATENCY));
            report_test($sformatf("retire %0d at pc %h", i, EXPECTED_RETIRES[i].pc),
                errors_before);
        end

        $display("%0d tests, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
            tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verif
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_unit.sv
verilog/decode.sv
verilog/execute.sv
verilog/result.sv
verilog/core_top.sv
verif/core_top_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module core_top_tb \
    -o core_top_tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/core_top_tb_sim > sim.log 2>&1
cat sim.log
grep -q "^Test completed successfully$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
